// ==== include/dds_defs.svh ====
`ifndef DDS_DEFS_SVH
`define DDS_DEFS_SVH

////////////////////////////////////////////////////////////////////////
// data word widths
////////////////////////////////////////////////////////////////////////

`define DDS_FREQ_W		48	// frequency tuning word
`define DDS_PHASE_W		14	// phase offset word
`define DDS_AMP_W		10	// dac full-scale current word

////////////////////////////////////////////////////////////////////////
// instruction framing
////////////////////////////////////////////////////////////////////////

`define DDS_INSTR_W		64	// shift register, left aligned
`define DDS_LEN_W		7	// bit count, holds up to 64

////////////////////////////////////////////////////////////////////////
// serial timing, in clk_in cycles
////////////////////////////////////////////////////////////////////////

`define DDS_SCLK_HALF		1	// sclk low or high phase length
`define DDS_SETUP_CYCLES	2	// csb rise to io_update

`endif

// ==== design/ad9912_pkg.sv ====
package ad9912_pkg;

	////////////////////////////////////////////////////////////////////////
	// update kinds, issued in this priority order
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_freq		= 2'd0,	// frequency tuning word
		op_phase	= 2'd1,	// phase offset
		op_amp		= 2'd2	// dac full-scale current
	} dds_op_t;

	////////////////////////////////////////////////////////////////////////
	// instruction header, 16 bits, sent first
	////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic		rw;	// 0 = write
		logic [1:0]	len;	// byte count code
		logic [12:0]	addr;	// start register address
	} instr_hdr_t;

	localparam logic rw_write = 1'b0;		// read/write bit for write
	localparam logic [1:0] len_two_bytes = 2'b01;	// w1 w0 = two bytes
	localparam logic [1:0] len_stream = 2'b11;	// stream until csb rises

	localparam logic [12:0] addr_ftw = 13'h01AB;	// ftw msb, counts down
	localparam logic [12:0] addr_phase = 13'h01AD;	// phase word msb
	localparam logic [12:0] addr_dac_fsc = 13'h040C;	// dac fsc msb

endpackage

// ==== design/dds_ctrl_pkg.sv ====
package dds_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////
	// serial shifter states
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		sh_idle	= 2'd0,	// csb high, waiting for load
		sh_low	= 2'd1,	// sclk low, sdio presents bit
		sh_high	= 2'd2,	// sclk high, chip samples
		sh_end	= 2'd3	// csb back high, frame_end out
	} shift_state_t;

	////////////////////////////////////////////////////////////////////////
	// update sequencer states
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		sq_idle		= 3'd0,	// link free
		sq_busy		= 3'd1,	// frame being built and shifted
		sq_wait		= 3'd2,	// io_update setup wait
		sq_update	= 3'd3,	// io_update high
		sq_done		= 3'd4	// wr_done high
	} seq_state_t;

endpackage

// ==== design/dds_update_latch.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_update_latch (
	input  logic				clk_in,		// system clock
	input  logic				reset_in,	// sync reset, active high
	input  logic [`DDS_FREQ_W-1:0]		freq_in,	// frequency word
	input  logic [`DDS_PHASE_W-1:0]		phase_in,	// phase word
	input  logic [`DDS_AMP_W-1:0]		amp_in,		// amplitude word
	input  logic				freq_dv_in,	// frequency strobe
	input  logic				phase_dv_in,	// phase strobe
	input  logic				amp_dv_in,	// amplitude strobe
	input  logic				link_free,	// from sequencer
	output logic				issue,		// one-cycle issue pulse
	output ad9912_pkg::dds_op_t		issue_op,	// kind being issued
	output logic [`DDS_FREQ_W-1:0]		issue_data	// zero-extended value
);

	logic [`DDS_FREQ_W-1:0] freq_val;	// held values
	logic [`DDS_PHASE_W-1:0] phase_val;
	logic [`DDS_AMP_W-1:0] amp_val;

	logic freq_pend;	// pending flags
	logic phase_pend;
	logic amp_pend;

	////////////////////////////////////////////////////////////////////////
	// value capture where the last strobe wins
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (freq_dv_in) freq_val <= freq_in;
		if (phase_dv_in) phase_val <= phase_in;
		if (amp_dv_in) amp_val <= amp_in;
	end

	////////////////////////////////////////////////////////////////////////
	// pending flags
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			freq_pend <= 1'b0;
			phase_pend <= 1'b0;
			amp_pend <= 1'b0;
		end else begin
			// clear the issued kind first
			if (issue && issue_op == ad9912_pkg::op_freq) freq_pend <= 1'b0;
			if (issue && issue_op == ad9912_pkg::op_phase) phase_pend <= 1'b0;
			if (issue && issue_op == ad9912_pkg::op_amp) amp_pend <= 1'b0;
			// a strobe in the issue cycle re-arms
			if (freq_dv_in) freq_pend <= 1'b1;
			if (phase_dv_in) phase_pend <= 1'b1;
			if (amp_dv_in) amp_pend <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// priority pick of freq over phase over amp
	////////////////////////////////////////////////////////////////////////

	assign issue = link_free & (freq_pend | phase_pend | amp_pend);	// same cycle

	always_comb begin
		if (freq_pend) begin
			issue_op = ad9912_pkg::op_freq;
			issue_data = freq_val;
		end else if (phase_pend) begin
			issue_op = ad9912_pkg::op_phase;
			issue_data = {{(`DDS_FREQ_W - `DDS_PHASE_W){1'b0}}, phase_val};
		end else begin
			issue_op = ad9912_pkg::op_amp;	// also the idle default
			issue_data = {{(`DDS_FREQ_W - `DDS_AMP_W){1'b0}}, amp_val};
		end
	end

	// sequencer must claim the link right after every issue
	a_issue_claims_link: assert property (@(posedge clk_in) disable iff (reset_in)
		issue |=> !link_free);

endmodule

// ==== design/dds_instr_builder.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_instr_builder (
	input  logic				clk_in,		// system clock
	input  logic				reset_in,	// sync reset, active high
	input  logic				issue,		// from latch
	input  ad9912_pkg::dds_op_t		issue_op,	// update kind
	input  logic [`DDS_FREQ_W-1:0]		issue_data,	// zero-extended value
	output logic				load,		// instr valid pulse
	output logic [`DDS_INSTR_W-1:0]		instr,		// left-aligned frame
	output logic [`DDS_LEN_W-1:0]		instr_len	// bits to shift
);

	localparam int len_w = `DDS_LEN_W;
	localparam int half_w = `DDS_INSTR_W / 2;	// short frame length

	ad9912_pkg::instr_hdr_t hdr;		// header for this opcode
	logic [`DDS_INSTR_W-1:0] instr_d;	// next frame
	logic [`DDS_LEN_W-1:0] len_d;		// next length

	////////////////////////////////////////////////////////////////////////
	// header and frame assembly
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		hdr.rw = ad9912_pkg::rw_write;
		case (issue_op)
			ad9912_pkg::op_freq: begin
				hdr.len = ad9912_pkg::len_stream;	// six data bytes
				hdr.addr = ad9912_pkg::addr_ftw;
				instr_d = {hdr, issue_data};		// 16 + 48
				len_d = len_w'(`DDS_INSTR_W);
			end
			ad9912_pkg::op_phase: begin
				hdr.len = ad9912_pkg::len_two_bytes;
				hdr.addr = ad9912_pkg::addr_phase;
				instr_d = {hdr, issue_data[15:0], {half_w{1'b0}}};
				len_d = len_w'(half_w);
			end
			default: begin
				hdr.len = ad9912_pkg::len_two_bytes;	// amplitude
				hdr.addr = ad9912_pkg::addr_dac_fsc;
				instr_d = {hdr, issue_data[15:0], {half_w{1'b0}}};
				len_d = len_w'(half_w);
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// output register, one cycle after issue
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) load <= 1'b0;
		else load <= issue;
	end

	always_ff @(posedge clk_in) begin
		if (issue) begin
			instr <= instr_d;
			instr_len <= len_d;
		end
	end

endmodule

// ==== design/dds_spi_shifter.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_spi_shifter (
	input  logic				clk_in,		// system clock
	input  logic				reset_in,	// sync reset, active high
	input  logic				load,		// start a frame
	input  logic [`DDS_INSTR_W-1:0]		instr,		// msb goes first
	input  logic [`DDS_LEN_W-1:0]		instr_len,	// bit count
	output logic				csb,		// chip select, low active
	output logic				sclk,		// serial clock, idles high
	output logic				sdio,		// serial data
	output logic				frame_end	// pulse as csb rises
);

	localparam int half_w = ($clog2(`DDS_SCLK_HALF) > 0) ? $clog2(`DDS_SCLK_HALF) : 1;
	localparam int msb = `DDS_INSTR_W - 1;

	dds_ctrl_pkg::shift_state_t state;

	logic [half_w-1:0] half_cnt;		// cycles spent in this sclk phase
	logic half_done;			// last cycle of the phase
	logic [`DDS_INSTR_W-1:0] shift_reg;	// bit on sdio sits at msb
	logic [`DDS_LEN_W-1:0] bits_left;	// includes the bit on sdio

	assign half_done = (half_cnt == half_w'(`DDS_SCLK_HALF - 1));

	////////////////////////////////////////////////////////////////////////
	// frame control and pin registers
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= dds_ctrl_pkg::sh_idle;
			csb <= 1'b1;
			sclk <= 1'b1;
			sdio <= 1'b0;
			frame_end <= 1'b0;
			half_cnt <= '0;
		end else begin
			frame_end <= 1'b0;	// pulse by default
			case (state)
				dds_ctrl_pkg::sh_idle: begin
					half_cnt <= '0;
					if (load) begin
						state <= dds_ctrl_pkg::sh_low;
						csb <= 1'b0;		// select chip
						sclk <= 1'b0;
						sdio <= instr[msb];	// first bit
					end
				end
				dds_ctrl_pkg::sh_low: begin
					if (half_done) begin
						state <= dds_ctrl_pkg::sh_high;
						sclk <= 1'b1;		// chip samples here
						half_cnt <= '0;
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				dds_ctrl_pkg::sh_high: begin
					if (half_done) begin
						half_cnt <= '0;
						if (bits_left == 1) begin
							state <= dds_ctrl_pkg::sh_end;
							csb <= 1'b1;	// deselect, sclk stays high
							sdio <= 1'b0;
							frame_end <= 1'b1;
						end else begin
							state <= dds_ctrl_pkg::sh_low;
							sclk <= 1'b0;
							sdio <= shift_reg[msb-1];	// next bit
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				dds_ctrl_pkg::sh_end: begin
					state <= dds_ctrl_pkg::sh_idle;	// one-cycle gap
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////
	// shift register and bit counter
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (state == dds_ctrl_pkg::sh_idle && load) begin
			shift_reg <= instr;
			bits_left <= instr_len;
		end else if (state == dds_ctrl_pkg::sh_high && half_done) begin
			shift_reg <= shift_reg << 1;	// advance after the rising edge
			bits_left <= bits_left - 1'b1;
		end
	end

	// chip stays selected for the whole frame, upstream holds off meanwhile
	a_frame_intact: assert property (@(posedge clk_in) disable iff (reset_in)
		(state inside {dds_ctrl_pkg::sh_low, dds_ctrl_pkg::sh_high}) |-> (!csb && !load));

endmodule

// ==== design/dds_update_sequencer.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_update_sequencer (
	input  logic	clk_in,		// system clock
	input  logic	reset_in,	// sync reset, active high
	input  logic	issue,		// update leaves the latch
	input  logic	frame_end,	// csb just rose
	output logic	io_update,	// chip register transfer
	output logic	wr_done,	// update finished
	output logic	link_free	// latch may issue
);

	localparam int wait_w = $clog2(`DDS_SETUP_CYCLES + 1);

	dds_ctrl_pkg::seq_state_t state;

	logic [wait_w-1:0] wait_cnt;	// setup cycles still to go

	////////////////////////////////////////////////////////////////////////
	// update FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= dds_ctrl_pkg::sq_idle;
		end else begin
			case (state)
				dds_ctrl_pkg::sq_idle: begin
					if (issue) state <= dds_ctrl_pkg::sq_busy;	// link claimed
				end
				dds_ctrl_pkg::sq_busy: begin
					// frame_end cycle is the first setup cycle
					if (frame_end) begin
						state <= (`DDS_SETUP_CYCLES > 1) ?
							dds_ctrl_pkg::sq_wait : dds_ctrl_pkg::sq_update;
					end
				end
				dds_ctrl_pkg::sq_wait: begin
					if (wait_cnt == 1) state <= dds_ctrl_pkg::sq_update;
				end
				dds_ctrl_pkg::sq_update: state <= dds_ctrl_pkg::sq_done;
				dds_ctrl_pkg::sq_done: state <= dds_ctrl_pkg::sq_idle;
				default: state <= dds_ctrl_pkg::sq_idle;
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (frame_end) wait_cnt <= wait_w'(`DDS_SETUP_CYCLES - 1);
		else if (state == dds_ctrl_pkg::sq_wait) wait_cnt <= wait_cnt - 1'b1;
	end

	assign io_update = (state == dds_ctrl_pkg::sq_update);
	assign wr_done = (state == dds_ctrl_pkg::sq_done);
	assign link_free = (state == dds_ctrl_pkg::sq_idle);

	// frame ends only on a claimed link and io_update lands after the setup wait
	a_setup_then_update: assert property (@(posedge clk_in) disable iff (reset_in)
		frame_end |-> (state == dds_ctrl_pkg::sq_busy)
			##`DDS_SETUP_CYCLES (io_update && !wr_done));

endmodule

// ==== design/dds_controller_top.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_controller_top (
	input  logic				clk_in,		// system clock
	input  logic				reset_in,	// sync reset, active high
	input  logic [`DDS_FREQ_W-1:0]		freq_in,	// frequency word
	input  logic [`DDS_PHASE_W-1:0]		phase_in,	// phase word
	input  logic [`DDS_AMP_W-1:0]		amp_in,		// amplitude word
	input  logic				freq_dv_in,	// frequency strobe
	input  logic				phase_dv_in,	// phase strobe
	input  logic				amp_dv_in,	// amplitude strobe
	output logic				sclk_out,	// to chip sclk
	output logic				reset_out,	// to chip reset
	output logic				csb_out,	// to chip csb
	output logic				sdio_out,	// to chip sdio
	output logic				io_update_out,	// to chip io_update
	output logic				wr_done_out	// update finished
);

	logic issue;				// latch -> builder, sequencer
	ad9912_pkg::dds_op_t issue_op;
	logic [`DDS_FREQ_W-1:0] issue_data;
	logic load;				// builder -> shifter
	logic [`DDS_INSTR_W-1:0] instr;
	logic [`DDS_LEN_W-1:0] instr_len;
	logic frame_end;			// shifter -> sequencer
	logic link_free;			// sequencer -> latch

	assign reset_out = reset_in;	// chip reset follows system reset

	////////////////////////////////////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////////////////////////////////////

	dds_update_latch u_latch (
		.clk_in(clk_in), .reset_in(reset_in),
		.freq_in(freq_in), .phase_in(phase_in), .amp_in(amp_in),
		.freq_dv_in(freq_dv_in), .phase_dv_in(phase_dv_in), .amp_dv_in(amp_dv_in),
		.link_free(link_free),
		.issue(issue), .issue_op(issue_op), .issue_data(issue_data)
	);

	dds_instr_builder u_builder (
		.clk_in(clk_in), .reset_in(reset_in),
		.issue(issue), .issue_op(issue_op), .issue_data(issue_data),
		.load(load), .instr(instr), .instr_len(instr_len)
	);

	dds_spi_shifter u_shifter (
		.clk_in(clk_in), .reset_in(reset_in),
		.load(load), .instr(instr), .instr_len(instr_len),
		.csb(csb_out), .sclk(sclk_out), .sdio(sdio_out), .frame_end(frame_end)
	);

	dds_update_sequencer u_sequencer (
		.clk_in(clk_in), .reset_in(reset_in),
		.issue(issue), .frame_end(frame_end),
		.io_update(io_update_out), .wr_done(wr_done_out), .link_free(link_free)
	);

endmodule

// ==== verif/dds_controller_tb.sv ====
`timescale 1ns/1ps
`include "dds_defs.svh"

module dds_controller_tb;

	localparam int cycle_limit = 4000;	// ~20 updates of 140 cycles plus margin
	localparam int k_freq = 0;		// tb-side update kinds
	localparam int k_phase = 1;
	localparam int k_amp = 2;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;	// x^32+x^22+x^2+x+1

	logic clk_in;
	logic reset_in;
	logic [`DDS_FREQ_W-1:0] freq_in;
	logic [`DDS_PHASE_W-1:0] phase_in;
	logic [`DDS_AMP_W-1:0] amp_in;
	logic freq_dv_in;
	logic phase_dv_in;
	logic amp_dv_in;
	logic sclk_out;
	logic reset_out;
	logic csb_out;
	logic sdio_out;
	logic io_update_out;
	logic wr_done_out;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int frame_cnt = 0;	// monitor counters
	int update_cnt = 0;
	int done_cnt = 0;
	int open_updates = 0;	// frames still owed an io_update
	int open_dones = 0;	// io_updates still owed a wr_done
	int err_base;		// snapshot at test start
	int frame_base;
	int update_base;
	int done_base;
	logic [63:0] got_q[$];	// decoded frames right aligned
	int got_len_q[$];
	logic [63:0] exp_q[$];
	int exp_len_q[$];
	logic [31:0] lfsr = 32'd72918;
	logic prev_sclk;
	logic prev_csb;
	logic [63:0] shift_acc;
	int bit_cnt;

	dds_controller_top uut (
		.clk_in(clk_in), .reset_in(reset_in),
		.freq_in(freq_in), .phase_in(phase_in), .amp_in(amp_in),
		.freq_dv_in(freq_dv_in), .phase_dv_in(phase_dv_in), .amp_dv_in(amp_dv_in),
		.sclk_out(sclk_out), .reset_out(reset_out), .csb_out(csb_out),
		.sdio_out(sdio_out), .io_update_out(io_update_out), .wr_done_out(wr_done_out)
	);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;	// 40 ns period
	end

	always @(posedge clk_in) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: no finish within %0d clock cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// serial decoder and pulse monitor sampled on clk_in
	////////////////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (reset_in) begin
			prev_sclk = 1'b1;
			prev_csb = 1'b1;
			shift_acc = '0;
			bit_cnt = 0;
		end else begin
			if (!csb_out && sclk_out && !prev_sclk) begin	// sclk rising where the chip samples
				shift_acc = {shift_acc[62:0], sdio_out};
				bit_cnt++;
			end
			if (csb_out && !prev_csb) begin			// frame closed
				if (open_updates != 0 || open_dones != 0) begin
					$display("error at %0t: frame closed before the previous update finished",
						$time);
					errors++;
				end
				got_q.push_back(shift_acc);
				got_len_q.push_back(bit_cnt);
				frame_cnt++;
				open_updates++;
				shift_acc = '0;
				bit_cnt = 0;
			end
			if (io_update_out) begin
				update_cnt++;
				if (!csb_out || open_updates == 0) begin
					$display("error at %0t: io_update_out pulsed with no closed frame", $time);
					errors++;
				end else begin
					open_updates--;
					open_dones++;
				end
			end
			if (wr_done_out) begin
				done_cnt++;
				if (open_dones == 0) begin
					$display("error at %0t: wr_done_out pulsed without io_update", $time);
					errors++;
				end else begin
					open_dones--;
				end
			end
			prev_sclk = sclk_out;
			prev_csb = csb_out;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////

	function automatic logic [47:0] rand_bits(input int n);
		logic [47:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];		// one step per bit
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ lfsr_taps;
			r = {r[46:0], b};
		end
		return r;
	endfunction

	// header is write bit then length code then 13-bit address
	function automatic void expect_frame(input int kind, input logic [47:0] data);
		logic [15:0] hdr;
		if (kind == k_freq) begin
			hdr = {1'b0, 2'b11, 13'h01AB};	// streaming ftw
			exp_q.push_back({hdr, data});
			exp_len_q.push_back(64);
		end else if (kind == k_phase) begin
			hdr = {1'b0, 2'b01, 13'h01AD};
			exp_q.push_back({32'h0, hdr, 2'b00, data[13:0]});
			exp_len_q.push_back(32);
		end else begin
			hdr = {1'b0, 2'b01, 13'h040C};	// dac fsc
			exp_q.push_back({32'h0, hdr, 6'h00, data[9:0]});
			exp_len_q.push_back(32);
		end
	endfunction

	task automatic drive_strobes(input logic f_en, input logic [47:0] f, input logic p_en,
			input logic [13:0] p, input logic a_en, input logic [9:0] a);
		@(posedge clk_in);
		freq_dv_in <= f_en;
		phase_dv_in <= p_en;
		amp_dv_in <= a_en;
		if (f_en) freq_in <= f;
		if (p_en) phase_in <= p;
		if (a_en) amp_in <= a;
		@(posedge clk_in);
		freq_dv_in <= 1'b0;	// one-cycle strobes
		phase_dv_in <= 1'b0;
		amp_dv_in <= 1'b0;
	endtask

	task automatic check_bit(input string name, input logic expv, input logic got);
		if (got !== expv) begin
			$display("error t=%0t %s: expected %b got %b", $time, name, expv, got);
			errors++;
		end
	endtask

	task automatic wait_dones(input int n);
		@(negedge clk_in);
		while (done_cnt < done_base + n) @(negedge clk_in);
	endtask

	task automatic begin_test();
		@(negedge clk_in);
		err_base = errors;
		frame_base = frame_cnt;
		update_base = update_cnt;
		done_base = done_cnt;
	endtask

	task automatic finish_test(input string name);
		logic [63:0] got;
		logic [63:0] expv;
		int got_len;
		int exp_len;
		if (got_q.size() != exp_q.size()) begin
			$display("error at %0t: expected %0d frames, decoded %0d", $time,
				exp_q.size(), got_q.size());
			errors++;
		end
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			got = got_q.pop_front();
			expv = exp_q.pop_front();
			got_len = got_len_q.pop_front();
			exp_len = exp_len_q.pop_front();
			if (got_len != exp_len) begin
				$display("error t=%0t sdio_out bits: expected %0d got %0d", $time,
					exp_len, got_len);
				errors++;
			end
			if (got !== expv) begin
				$display("error t=%0t sdio_out: expected %h got %h", $time, expv, got);
				errors++;
			end
		end
		got_q.delete();
		got_len_q.delete();
		exp_q.delete();
		exp_len_q.delete();
		if (update_cnt - update_base != frame_cnt - frame_base) begin
			$display("error t=%0t io_update_out pulses: expected %0d got %0d", $time,
				frame_cnt - frame_base, update_cnt - update_base);
			errors++;
		end
		if (done_cnt - done_base != frame_cnt - frame_base) begin
			$display("error t=%0t wr_done_out pulses: expected %0d got %0d", $time,
				frame_cnt - frame_base, done_cnt - done_base);
			errors++;
		end
		tests_run++;
		if (errors == err_base) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, errors - err_base);
		end
	endtask

	////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////

	task automatic reset_values();
		@(posedge clk_in);				// reset held since time 0
		begin_test();
		check_bit("reset_out", 1'b1, reset_out);
		@(posedge clk_in);
		reset_in <= 1'b0;				// 2 cycles of reset
		@(negedge clk_in);
		check_bit("reset_out", 1'b0, reset_out);
		check_bit("csb_out", 1'b1, csb_out);
		check_bit("sclk_out", 1'b1, sclk_out);
		check_bit("sdio_out", 1'b0, sdio_out);
		check_bit("io_update_out", 1'b0, io_update_out);
		check_bit("wr_done_out", 1'b0, wr_done_out);
		finish_test("reset");
	endtask

	task automatic single_freq_update();
		begin_test();
		expect_frame(k_freq, 48'h1234_5678_9ABC);
		drive_strobes(1'b1, 48'h1234_5678_9ABC, 1'b0, '0, 1'b0, '0);
		wait_dones(1);
		finish_test("single frequency");
	endtask

	task automatic phase_amp_updates();
		begin_test();
		expect_frame(k_phase, 48'h2A5F);
		drive_strobes(1'b0, '0, 1'b1, 14'h2A5F, 1'b0, '0);
		wait_dones(1);
		expect_frame(k_amp, 48'h3C7);
		drive_strobes(1'b0, '0, 1'b0, '0, 1'b1, 10'h3C7);
		wait_dones(2);
		finish_test("phase and amplitude");
	endtask

	task automatic same_cycle_priority();
		begin_test();
		expect_frame(k_freq, 48'hFEDC_BA98_7654);	// priority order
		expect_frame(k_phase, 48'h1001);
		expect_frame(k_amp, 48'h201);
		drive_strobes(1'b1, 48'hFEDC_BA98_7654, 1'b1, 14'h1001, 1'b1, 10'h201);
		wait_dones(3);
		finish_test("same-cycle strobes");
	endtask

	task automatic freq_overwrite();
		logic extra;
		extra = 1'b0;
		begin_test();
		expect_frame(k_phase, 48'h0ABC);
		expect_frame(k_freq, 48'h0000_2222_3333);	// second value wins
		drive_strobes(1'b0, '0, 1'b1, 14'h0ABC, 1'b0, '0);
		@(negedge clk_in);
		while (csb_out) @(negedge clk_in);		// phase frame on the link
		drive_strobes(1'b1, 48'h0000_1111_0000, 1'b0, '0, 1'b0, '0);
		drive_strobes(1'b1, 48'h0000_2222_3333, 1'b0, '0, 1'b0, '0);
		wait_dones(2);
		repeat (8) begin
			@(negedge clk_in);
			if (!csb_out) extra = 1'b1;
		end
		if (extra) begin
			$display("error at %0t: a third frame started after the overwrite", $time);
			errors++;
		end
		finish_test("frequency overwrite");
	endtask

	task automatic random_updates();
		int kind;
		logic [47:0] data;
		begin_test();
		for (int i = 0; i < 12; i++) begin
			kind = int'(rand_bits(2)) % 3;
			if (kind == k_freq) data = rand_bits(48);
			else if (kind == k_phase) data = rand_bits(14);
			else data = rand_bits(10);
			expect_frame(kind, data);
			drive_strobes(kind == k_freq, data, kind == k_phase, data[13:0],
				kind == k_amp, data[9:0]);
			wait_dones(i + 1);
		end
		finish_test("random updates");
	endtask

	initial begin
		reset_in = 1'b1;
		freq_in = '0;
		phase_in = '0;
		amp_in = '0;
		freq_dv_in = 1'b0;
		phase_dv_in = 1'b0;
		amp_dv_in = 1'b0;
		reset_values();
		single_freq_update();
		phase_amp_updates();
		same_cycle_priority();
		freq_overwrite();
		random_updates();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
design/ad9912_pkg.sv
design/dds_ctrl_pkg.sv
design/dds_update_latch.sv
design/dds_instr_builder.sv
design/dds_spi_shifter.sv
design/dds_update_sequencer.sv
design/dds_controller_top.sv
verif/dds_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DDS controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module dds_controller_tb \
	-o sim_dds
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_dds 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF '>>> PASS'; then
	exit 0
fi
echo "pass message not found"
exit 1
